/* verilog/eg_macros.svh */
`ifndef EG_MACROS_SVH
`define EG_MACROS_SVH

// operator slots in one sample
`define EG_SLOTS 32

// slot index width
`define SLOT_W 5

// attenuation, 1 lsb is about 0.094 dB
`define EG_W 10

// global envelope counter
`define EG_CNT_W 15

`define TL_W 7   // total level
`define AM_W 7   // amplitude modulation input
`define KC_W 5   // keycode, also the rate2 side field

`endif

/* verilog/eg_pkg.sv */
`include "eg_macros.svh"

package eg_pkg;

    typedef enum logic [1:0] {
        ATTACK  = 2'd0,
        DECAY1  = 2'd1,
        DECAY2  = 2'd2,
        RELEASE = 2'd3
    } eg_state_t;

    // rate view, written with wr_sel low
    typedef struct packed {
        logic [4:0] arate;
        logic [4:0] rate1;
        logic [1:0] ks;     // key scaling depth
        logic [3:0] rrate;
    } rate_word_t;

    // level view, written with wr_sel high
    typedef struct packed {
        logic [3:0]       d1l;    // sustain level
        logic [`TL_W-1:0] tl;
        logic [1:0]       ams;
        logic             amsen;
        logic             keyon;
        logic             spare;
    } level_word_t;

    typedef union packed {
        rate_word_t  rate;
        level_word_t lvl;
    } reg_word_u;

endpackage

/* verilog/eg_cfg_if.sv */
`timescale 1ns/1ps
`include "eg_macros.svh"

// per-slot parameters, each aligned to the stage that consumes it
interface eg_cfg_if;
    logic [3:0]       d1l_i;
    logic [4:0]       arate_ii;
    logic [4:0]       rate1_ii;
    logic [4:0]       rate2_ii;
    logic [3:0]       rrate_ii;
    logic             keyon_ii;
    logic [`KC_W-1:0] keycode_iii;
    logic [1:0]       ks_iii;
    logic [`TL_W-1:0] tl_vii;
    logic [1:0]       ams_vii;
    logic             amsen_vii;

    modport cfg_src (
        output d1l_i, arate_ii, rate1_ii, rate2_ii, rrate_ii, keyon_ii,
        output keycode_iii, ks_iii, tl_vii, ams_vii, amsen_vii
    );

    modport cfg_dst (
        input d1l_i, arate_ii, rate1_ii, rate2_ii, rrate_ii, keyon_ii,
        input keycode_iii, ks_iii, tl_vii, ams_vii, amsen_vii
    );

endinterface

/* verilog/slot_timer.sv */
`timescale 1ns/1ps
`include "eg_macros.svh"

module slot_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    output logic [`SLOT_W-1:0] slot,
    output logic               zero,
    output logic [`SLOT_W-1:0] out_slot
);

    // eg_out is registered at stage XI
    localparam int OUT_LAG = 10;

    localparam logic [`SLOT_W-1:0] LAST_SLOT = `SLOT_W'(`EG_SLOTS - 1);

    // slot currently at stage I
    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
        end else if (cen) begin
            if (slot == LAST_SLOT)
                slot <= '0;
            else
                slot <= slot + `SLOT_W'(1);
        end
    end

    assign zero = slot == LAST_SLOT;   // sample start

    // wraps modulo 32 on its own
    assign out_slot = slot - `SLOT_W'(OUT_LAG);

endmodule

/* verilog/shift_line.sv */
`timescale 1ns/1ps

// per-slot state storage, one stage per cen step
module shift_line #(
    parameter int               width  = 1,
    parameter int               stages = 32,
    parameter logic [width-1:0] rstval = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic [width-1:0] din,
    output logic [width-1:0] drop
);

    logic [stages*width-1:0] bits;

    always_ff @(posedge clk) begin
        if (rst) begin
            bits <= {stages{rstval}};
        end else if (cen) begin
            bits <= {bits[(stages-1)*width-1:0], din};   // newest at the bottom
        end
    end

    assign drop = bits[stages*width-1 -: width];

endmodule

/* verilog/op_regs.sv */
`timescale 1ns/1ps
`include "eg_macros.svh"

module op_regs import eg_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic [`SLOT_W-1:0] slot,
    input  logic               wr_valid,
    input  logic               wr_sel,
    input  logic [`SLOT_W-1:0] wr_slot,
    input  reg_word_u          wr_data,
    input  logic [`KC_W-1:0]   wr_keycode,
    output logic               wr_ready,
    eg_cfg_if.cfg_src          cfg
);

    reg_word_u        rate_mem  [`EG_SLOTS];
    reg_word_u        lvl_mem   [`EG_SLOTS];
    logic [`KC_W-1:0] kc_mem    [`EG_SLOTS];
    logic [4:0]       rate2_mem [`EG_SLOTS];

    // one-entry holding buffer
    logic               hold_full;
    logic               hold_sel;
    logic [`SLOT_W-1:0] hold_slot;
    reg_word_u          hold_data;
    logic [`KC_W-1:0]   hold_side;

    logic [`SLOT_W-1:0] rd_ii;
    logic [`SLOT_W-1:0] rd_iii;
    logic [`SLOT_W-1:0] rd_vii;

    assign wr_ready = !hold_full;

    always_ff @(posedge clk) begin
        if (rst)
            hold_full <= 1'b0;
        else if (wr_valid && wr_ready)
            hold_full <= 1'b1;
        else if (cen)
            hold_full <= 1'b0;   // committed below
    end

    always_ff @(posedge clk) begin
        if (wr_valid && wr_ready) begin
            hold_sel  <= wr_sel;
            hold_slot <= wr_slot;
            hold_data <= wr_data;
            hold_side <= wr_keycode;   // rate2 when wr_sel is low
        end
    end

    // config starts cleared so every key reads off
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EG_SLOTS; i++) begin
                rate_mem[i]  <= '0;
                lvl_mem[i]   <= '0;
                kc_mem[i]    <= '0;
                rate2_mem[i] <= '0;
            end
        end else if (cen && hold_full) begin
            if (hold_sel) begin
                lvl_mem[hold_slot] <= hold_data;
                kc_mem[hold_slot]  <= hold_side;
            end else begin
                rate_mem[hold_slot]  <= hold_data;
                rate2_mem[hold_slot] <= hold_side;
            end
        end
    end

    // slot seen by each later stage
    assign rd_ii  = slot - `SLOT_W'(1);
    assign rd_iii = slot - `SLOT_W'(2);
    assign rd_vii = slot - `SLOT_W'(6);

    assign cfg.d1l_i       = lvl_mem[slot].lvl.d1l;
    assign cfg.arate_ii    = rate_mem[rd_ii].rate.arate;
    assign cfg.rate1_ii    = rate_mem[rd_ii].rate.rate1;
    assign cfg.rate2_ii    = rate2_mem[rd_ii];
    assign cfg.rrate_ii    = rate_mem[rd_ii].rate.rrate;
    assign cfg.keyon_ii    = lvl_mem[rd_ii].lvl.keyon;
    assign cfg.keycode_iii = kc_mem[rd_iii];
    assign cfg.ks_iii      = rate_mem[rd_iii].rate.ks;
    assign cfg.tl_vii      = lvl_mem[rd_vii].lvl.tl;
    assign cfg.ams_vii     = lvl_mem[rd_vii].lvl.ams;
    assign cfg.amsen_vii   = lvl_mem[rd_vii].lvl.amsen;

endmodule

/* verilog/env_gen.sv */
`timescale 1ns/1ps
`include "eg_macros.svh"

module env_gen import eg_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic             zero,
    eg_cfg_if.cfg_dst        cfg,
    input  logic [`AM_W-1:0] am,
    output logic             pg_rst,
    output logic [`EG_W-1:0] eg_out
);

    localparam logic [`EG_W-1:0] EG_MAX = '1;

    logic [1:0]           cnt_base;
    logic [`EG_CNT_W-1:0] eg_cnt;
    logic [4:0]           d1level_ii;
    logic [4:0]           cfg_iii;
    logic [1:0]           state_loop;
    eg_state_t            state_ii, state_iii, state_iv, state_v, state_vi;
    logic [`EG_W-1:0]     eg_ii, eg_vi, eg_vii, eg_viii;
    logic                 keyon_last_ii, keyon_now_ii, keyoff_now_ii;
    logic                 ar_off_ii, ar_off_vi;
    logic [`KC_W-1:0]     ks_add;
    logic [6:0]           pre_rate_iii;
    logic [5:0]           rate_iv, rate_v;
    logic [5:1]           rate_vi;
    logic [3:0]           cnt_top, cnt_shift;
    logic [2:0]           cnt_v;
    logic                 cnt_out, sum_up;
    logic [7:0]           step_idx;
    logic                 step_v, step_vi;
    logic [8:0]           ar_sum0;
    logic [`EG_W-1:0]     ar_sum, ar_result;
    logic [3:0]           dec_step;
    logic [9:0]           am_final;
    logic [11:0]          sum_vii;

    // global counter, one tick every three samples
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_base <= 2'd0;
            eg_cnt   <= '0;
        end else if (cen && zero) begin
            if (cnt_base == 2'd2) begin
                cnt_base <= 2'd0;
                eg_cnt   <= eg_cnt + 1'b1;
            end else begin
                cnt_base <= cnt_base + 2'd1;
            end
        end
    end

    assign keyon_now_ii  = cfg.keyon_ii && !keyon_last_ii;
    assign keyoff_now_ii = !cfg.keyon_ii && keyon_last_ii;
    assign ar_off_ii     = keyon_now_ii && cfg.arate_ii == 5'h1f;   // instant attack
    assign state_ii      = eg_state_t'(state_loop);

    // stages I and II
    always_ff @(posedge clk) begin
        if (rst) begin
            d1level_ii <= '0;
            pg_rst     <= 1'b0;
            state_iii  <= RELEASE;
            cfg_iii    <= '0;
        end else if (cen) begin
            d1level_ii <= cfg.d1l_i == 4'd15 ? 5'h10 : {1'b0, cfg.d1l_i};   // 15 is 48 dB
            pg_rst     <= keyon_now_ii;
            if (keyoff_now_ii) begin
                state_iii <= RELEASE;
                cfg_iii   <= {cfg.rrate_ii, 1'b1};
            end else if (keyon_now_ii) begin
                state_iii <= ATTACK;
                cfg_iii   <= cfg.arate_ii;
            end else begin
                case (state_ii)
                    ATTACK: begin
                        state_iii <= eg_ii == '0 ? DECAY1 : ATTACK;
                        cfg_iii   <= eg_ii == '0 ? cfg.rate1_ii : cfg.arate_ii;
                    end
                    DECAY1: begin
                        state_iii <= eg_ii[9:5] >= d1level_ii ? DECAY2 : DECAY1;
                        cfg_iii   <= eg_ii[9:5] >= d1level_ii ? cfg.rate2_ii : cfg.rate1_ii;
                    end
                    DECAY2: begin
                        state_iii <= DECAY2;
                        cfg_iii   <= cfg.rate2_ii;
                    end
                    default: begin
                        state_iii <= RELEASE;
                        cfg_iii   <= {cfg.rrate_ii, 1'b1};
                    end
                endcase
            end
        end
    end

    always_comb begin
        ks_add       = cfg.keycode_iii >> (2'd3 - cfg.ks_iii);
        pre_rate_iii = cfg_iii == '0 ? 7'd0 : {1'b0, cfg_iii, 1'b0} + {2'b0, ks_add};
        // faster rates look at lower counter bits
        cnt_top   = state_iv == ATTACK ? 4'd11 : 4'd12;
        cnt_shift = rate_iv[5:2] < cnt_top ? cnt_top - rate_iv[5:2] : 4'd0;
    end

    // 8-step pattern
    always_comb begin
        if (rate_v[5:4] == 2'b11) begin
            if (rate_v[5:2] == 4'hf && state_v == ATTACK)
                step_idx = 8'b11111111;
            else
                case (rate_v[1:0])
                    2'd0: step_idx = 8'b00000000;
                    2'd1: step_idx = 8'b10001000;
                    2'd2: step_idx = 8'b10101010;
                    default: step_idx = 8'b11101110;
                endcase
        end else if (rate_v[5:2] == 4'd0 && state_v != ATTACK) begin
            step_idx = 8'b11111110;   // slowest decay
        end else begin
            case (rate_v[1:0])
                2'd0: step_idx = 8'b10101010;
                2'd1: step_idx = 8'b11101010;
                2'd2: step_idx = 8'b11101110;
                default: step_idx = 8'b11111110;
            endcase
        end
        step_v = rate_v[5:1] == '0 ? 1'b0 : step_idx[cnt_v];   // zero rate holds
    end

    // stages III to V
    always_ff @(posedge clk) begin
        if (rst) begin
            state_iv <= RELEASE;
            state_v  <= RELEASE;
            state_vi <= RELEASE;
            rate_iv  <= '0;
            rate_v   <= '0;
            rate_vi  <= '0;
            cnt_v    <= '0;
            sum_up   <= 1'b0;
            step_vi  <= 1'b0;
        end else if (cen) begin
            state_iv <= state_iii;
            rate_iv  <= pre_rate_iii[6] ? 6'd63 : pre_rate_iii[5:0];
            state_v  <= state_iv;
            rate_v   <= rate_iv;
            cnt_v    <= 3'(eg_cnt >> cnt_shift);
            state_vi <= state_v;
            rate_vi  <= rate_v[5:1];
            sum_up   <= cnt_v[0] != cnt_out;   // counter bit moved since last sample
            step_vi  <= step_v;
        end
    end

    always_comb begin
        case (rate_vi[5:2])
            4'b1101: ar_sum0 = {2'd0, eg_vi[9:3]} + 9'd1;
            4'b1110, 4'b1111: ar_sum0 = {1'd0, eg_vi[9:2]} + 9'd1;
            default: ar_sum0 = {3'd0, eg_vi[9:4]} + 9'd1;
        endcase
        if (rate_vi[5:4] == 2'b11)
            ar_sum = step_vi ? {ar_sum0, 1'b0} : {1'b0, ar_sum0};
        else
            ar_sum = step_vi ? {1'b0, ar_sum0} : '0;
        ar_result = ar_sum < eg_vi ? eg_vi - ar_sum : '0;
        case (rate_vi[5:2])
            4'b1100: dec_step = {2'd0, step_vi, ~step_vi};
            4'b1101: dec_step = {1'd0, step_vi, ~step_vi, 1'b0};
            4'b1110: dec_step = {step_vi, ~step_vi, 2'b0};
            4'b1111: dec_step = 4'd8;
            default: dec_step = {2'd0, step_vi, 1'b0};
        endcase
        am_final = cfg.amsen_vii && cfg.ams_vii != 2'd0 ? 10'(am) << cfg.ams_vii : '0;
        sum_vii  = {2'b0, cfg.tl_vii, 3'b0} + {2'b0, eg_vii} + {1'b0, am_final, 1'b0};
    end

    // stages VI and VII
    always_ff @(posedge clk) begin
        if (rst) begin
            eg_vii  <= EG_MAX;
            eg_viii <= EG_MAX;
        end else if (cen) begin
            if (ar_off_vi)
                eg_vii <= '0;
            else if (state_vi == ATTACK)
                if (sum_up && eg_vi != '0)
                    eg_vii <= rate_vi == 5'h1f ? '0 : ar_result;
                else
                    eg_vii <= eg_vi;
            else if (sum_up)
                eg_vii <= eg_vi <= EG_MAX - `EG_W'(8) ? eg_vi + `EG_W'(dec_step) : EG_MAX;
            else
                eg_vii <= eg_vi;
            eg_viii <= sum_vii[11:10] != 2'b0 ? EG_MAX : sum_vii[9:0];
        end
    end

    // level loop, VII back to II then on to VI
    shift_line #(.width(`EG_W), .stages(27), .rstval(EG_MAX)) u_level_loop (
        .clk, .rst, .cen, .din(eg_vii), .drop(eg_ii)
    );
    shift_line #(.width(`EG_W), .stages(4), .rstval(EG_MAX)) u_level_fwd (
        .clk, .rst, .cen, .din(eg_ii), .drop(eg_vi)
    );
    shift_line #(.width(`EG_W), .stages(3), .rstval(EG_MAX)) u_out_pad (
        .clk, .rst, .cen, .din(eg_viii), .drop(eg_out)
    );
    shift_line #(.width(2), .stages(31), .rstval(2'(RELEASE))) u_state_loop (
        .clk, .rst, .cen, .din(state_iii), .drop(state_loop)
    );
    shift_line #(.width(1), .stages(32)) u_key_hist (
        .clk, .rst, .cen, .din(cfg.keyon_ii), .drop(keyon_last_ii)
    );
    shift_line #(.width(1), .stages(32)) u_cnt_phase (
        .clk, .rst, .cen, .din(cnt_v[0]), .drop(cnt_out)
    );
    shift_line #(.width(1), .stages(4)) u_ar_off (
        .clk, .rst, .cen, .din(ar_off_ii), .drop(ar_off_vi)
    );

endmodule

/* verilog/eg_top.sv */
`timescale 1ns/1ps
`include "eg_macros.svh"

module eg_top import eg_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic [`AM_W-1:0]   am,
    // host write port
    input  logic               wr_valid,
    output logic               wr_ready,
    input  logic [`SLOT_W-1:0] wr_slot,
    input  logic               wr_sel,
    input  reg_word_u          wr_data,
    input  logic [`KC_W-1:0]   wr_keycode,   // rate2 with the rate view
    // envelope output
    output logic               pg_rst,
    output logic [`EG_W-1:0]   eg_out,
    output logic [`SLOT_W-1:0] out_slot,
    output logic               sample_start
);

    logic [`SLOT_W-1:0] slot;   // slot at stage I

    eg_cfg_if cfg ();

    slot_timer u_timer (
        .clk,
        .rst,
        .cen,
        .slot,
        .zero     (sample_start),
        .out_slot
    );

    op_regs u_regs (
        .clk,
        .rst,
        .cen,
        .slot,
        .wr_valid,
        .wr_sel,
        .wr_slot,
        .wr_data,
        .wr_keycode,
        .wr_ready,
        .cfg        (cfg.cfg_src)
    );

    env_gen u_env (
        .clk,
        .rst,
        .cen,
        .zero   (sample_start),
        .cfg    (cfg.cfg_dst),
        .am,
        .pg_rst,
        .eg_out
    );

endmodule

/* testbench/eg_checker.sv */
`timescale 1ns/1ps
`include "eg_macros.svh"

module eg_checker import eg_pkg::*; (
    input logic               clk,
    input logic               rst,
    input logic               cen,
    input logic [`AM_W-1:0]   am,
    input logic               wr_valid,
    input logic               wr_ready,
    input logic [`SLOT_W-1:0] wr_slot,
    input logic               wr_sel,
    input reg_word_u          wr_data,
    input logic               pg_rst,
    input logic [`EG_W-1:0]   eg_out,
    input logic [`SLOT_W-1:0] out_slot,
    input logic               sample_start
);

    localparam int MODE_IDLE  = 0;
    localparam int MODE_RESET = 1;   // everything at max attenuation
    localparam int MODE_LEVEL = 2;   // keyed slots at their exact level
    localparam int MODE_MONO  = 3;   // direction follows the key
    localparam int MODE_REL   = 4;   // waiting for all slots at max
    localparam int LVL_MAX    = 1023;
    localparam int OUT_LAG    = 10;  // eg_out trails stage I by ten steps

    int    mode = MODE_IDLE;
    string test_name = "none";
    int    test_errs, printed, pass_cnt, fail_cnt;
    int    pg_cnt, rise_cnt, hs_cnt, max_run;
    bit    released;
    logic  full_m;   // model of the holding buffer
    int    slot_m;   // slot at stage I

    // last written parameters per slot
    int tl_m [`EG_SLOTS];
    int ams_m [`EG_SLOTS];
    bit amsen_m [`EG_SLOTS];
    bit keyon_m [`EG_SLOTS];
    int settle [`EG_SLOTS];   // samples until a written slot is checked again
    int prev_out [`EG_SLOTS];
    bit have_prev [`EG_SLOTS];

    initial begin
        for (int i = 0; i < `EG_SLOTS; i++) begin
            tl_m[i] = 0;
            ams_m[i] = 0;
            amsen_m[i] = 0;
            keyon_m[i] = 0;
            settle[i] = 0;
            have_prev[i] = 0;
        end
    end

    function automatic int expected_out(int s);
        int v;
        v = tl_m[s] * 8;
        if (amsen_m[s] && ams_m[s] != 0)
            v += int'(am) * (1 << ams_m[s]) * 2;
        return v > LVL_MAX ? LVL_MAX : v;
    endfunction

    task automatic report_value(input string what, input int exp, input int act);
        test_errs++;
        if (printed < 10)
            $display("[ERROR] %s %s expected %0d actual %0d", test_name, what, exp, act);
        printed++;
    endtask

    task automatic note_failure(input string msg);
        test_errs++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic set_mode(input int m);
        mode = m;
        max_run = 0;
        released = 1'b0;
        for (int i = 0; i < `EG_SLOTS; i++)
            have_prev[i] = 0;
    endtask

    task automatic start_test(input string name, input int m);
        test_name = name;
        test_errs = 0;
        printed = 0;
        pg_cnt = 0;
        rise_cnt = 0;
        hs_cnt = 0;
        set_mode(m);
    endtask

    task automatic check_writes(input int issued);
        if (hs_cnt != issued)
            report_value("accepted writes", issued, hs_cnt);
    endtask

    task automatic end_test();
        if (pg_cnt != rise_cnt)
            report_value("pg_rst pulses", rise_cnt, pg_cnt);
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s: passed", test_name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", test_name, test_errs);
        end
        mode = MODE_IDLE;
    endtask

    task automatic summary();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    endtask

    always @(posedge clk) begin : watch
        int  s;
        bit  hs;
        int  exp_out;
        bit  exp_start;
        s  = int'(out_slot);
        hs = wr_valid && wr_ready;
        exp_out   = (slot_m + `EG_SLOTS - OUT_LAG) % `EG_SLOTS;
        exp_start = slot_m == `EG_SLOTS - 1;
        if (rst) begin
            full_m = 1'b0;
            slot_m = 0;
        end else begin
            if (wr_ready !== !full_m)
                report_value("wr_ready", !full_m, wr_ready);
            if (sample_start !== exp_start)
                report_value("sample_start", exp_start, sample_start);
            if (out_slot !== `SLOT_W'(exp_out))
                report_value("out_slot", exp_out, out_slot);
            if (cen) begin
                if (pg_rst)
                    pg_cnt++;
                if ($isunknown(eg_out))
                    note_failure("eg_out has unknown bits");
                case (mode)
                    MODE_RESET: begin
                        if (eg_out != LVL_MAX)
                            report_value($sformatf("slot %0d eg_out", s), LVL_MAX, eg_out);
                    end
                    MODE_LEVEL: begin
                        if (keyon_m[s] && settle[s] == 0 && eg_out != expected_out(s))
                            report_value($sformatf("slot %0d eg_out", s),
                                         expected_out(s), eg_out);
                    end
                    MODE_MONO: begin
                        if (settle[s] == 0) begin
                            if (have_prev[s] && keyon_m[s] && eg_out > prev_out[s])
                                report_value($sformatf("slot %0d eg_out at most", s),
                                             prev_out[s], eg_out);
                            if (have_prev[s] && !keyon_m[s] && eg_out < prev_out[s])
                                report_value($sformatf("slot %0d eg_out at least", s),
                                             prev_out[s], eg_out);
                            prev_out[s] = eg_out;
                            have_prev[s] = 1;
                        end else begin
                            have_prev[s] = 0;
                        end
                    end
                    MODE_REL: begin
                        if (eg_out == LVL_MAX) begin
                            max_run++;
                        end else begin
                            if (released)
                                report_value($sformatf("slot %0d eg_out", s), LVL_MAX, eg_out);
                            max_run = 0;
                        end
                        if (max_run >= `EG_SLOTS)
                            released = 1'b1;   // whole sample at max
                    end
                    default: ;
                endcase
                if (settle[s] > 0)
                    settle[s]--;
                slot_m = (slot_m + 1) % `EG_SLOTS;
            end
            if (hs) begin
                hs_cnt++;
                settle[wr_slot] = 3;
                if (wr_sel) begin
                    if (wr_data.lvl.keyon && !keyon_m[wr_slot])
                        rise_cnt++;
                    keyon_m[wr_slot] = wr_data.lvl.keyon;
                    tl_m[wr_slot]    = int'(wr_data.lvl.tl);
                    ams_m[wr_slot]   = int'(wr_data.lvl.ams);
                    amsen_m[wr_slot] = wr_data.lvl.amsen;
                end
            end
            // buffer fills on a transfer, empties on the next cen clock
            full_m = hs ? 1'b1 : (cen ? 1'b0 : full_m);
        end
    end

endmodule

/* testbench/tb_eg.sv */
`timescale 1ns/1ps
`include "eg_macros.svh"

module tb_eg import eg_pkg::*; ();

    localparam int HOST_WRITES  = 120;
    localparam int REL_SAMPLES  = 400;   // 8 per counter tick, one tick per 3 samples
    // sample budget of all tests together
    localparam int TEST_SAMPLES = 3 + 30 + 30 + 40 + 100 + REL_SAMPLES + 20;
    localparam longint WATCHDOG_NS = longint'(TEST_SAMPLES) * 32 * 2 * 8 + 20000;

    logic               clk;
    logic               rst;
    logic               cen;
    logic [`AM_W-1:0]   am;
    logic               wr_valid;
    logic               wr_ready;
    logic [`SLOT_W-1:0] wr_slot;
    logic               wr_sel;
    reg_word_u          wr_data;
    logic [`KC_W-1:0]   wr_keycode;
    logic               pg_rst;
    logic [`EG_W-1:0]   eg_out;
    logic [`SLOT_W-1:0] out_slot;
    logic               sample_start;

    logic [`SLOT_W-1:0] keyed [8];
    int                 waited;

    eg_top i_dut (
        .clk, .rst, .cen, .am,
        .wr_valid, .wr_ready, .wr_slot, .wr_sel, .wr_data, .wr_keycode,
        .pg_rst, .eg_out, .out_slot, .sample_start
    );

    eg_checker u_chk (
        .clk, .rst, .cen, .am,
        .wr_valid, .wr_ready, .wr_slot, .wr_sel, .wr_data,
        .pg_rst, .eg_out, .out_slot, .sample_start
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // counts whole samples, returns on a falling edge
    task automatic wait_samples(input int n);
        int k;
        k = 0;
        while (k < n) begin
            @(posedge clk);
            if (cen && sample_start)
                k++;
        end
        @(negedge clk);
    endtask

    task automatic host_write(input logic sel, input logic [`SLOT_W-1:0] s,
                              input reg_word_u data, input logic [`KC_W-1:0] side);
        int tries;
        tries = 0;
        wr_sel     = sel;
        wr_slot    = s;
        wr_data    = data;
        wr_keycode = side;
        wr_valid   = 1'b1;
        @(posedge clk);
        while (!wr_ready && tries < 100) begin
            tries++;
            @(posedge clk);
        end
        if (!wr_ready)
            u_chk.note_failure("host write was never accepted");
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    task automatic write_rate(input int s, input int ar, input int r1, input int r2,
                              input int ks, input int rr);
        reg_word_u w;
        w = '0;
        w.rate.arate = 5'(ar);
        w.rate.rate1 = 5'(r1);
        w.rate.ks    = 2'(ks);
        w.rate.rrate = 4'(rr);
        host_write(1'b0, 5'(s), w, 5'(r2));   // side field is rate2 here
    endtask

    task automatic write_level(input int s, input int d1l, input int tl, input int ams,
                               input bit amsen, input bit keyon, input int kc);
        reg_word_u w;
        w = '0;
        w.lvl.d1l   = 4'(d1l);
        w.lvl.tl    = 7'(tl);
        w.lvl.ams   = 2'(ams);
        w.lvl.amsen = amsen;
        w.lvl.keyon = keyon;
        host_write(1'b1, 5'(s), w, 5'(kc));
    endtask

    initial begin
        void'($urandom(64));
        rst = 1'b1;
        cen = 1'b0;
        am = '0;
        wr_valid = 1'b0;
        wr_slot = '0;
        wr_sel = 1'b0;
        wr_data = '0;
        wr_keycode = '0;

        fork
            forever begin
                @(negedge clk);
                cen = ($urandom % 4) != 0;   // high three clocks in four on average
            end
            begin
                #(WATCHDOG_NS);
                $display("watchdog expired, the run did not finish in time");
                $display("TEST FAILED");
                $finish;
            end
        join_none

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        u_chk.start_test("reset", 1);
        wait_samples(3);
        u_chk.end_test();

        // random traffic, keys kept off
        u_chk.start_test("host_port", 0);
        for (int i = 0; i < HOST_WRITES; i++) begin
            if ($urandom % 2)
                write_rate($urandom % 32, $urandom % 32, $urandom % 32, $urandom % 32,
                           $urandom % 4, $urandom % 16);
            else
                write_level($urandom % 32, $urandom % 16, $urandom % 128, $urandom % 4,
                            $urandom % 2, 1'b0, $urandom % 32);
            repeat ($urandom % 3) @(negedge clk);
        end
        wait_samples(2);
        u_chk.check_writes(HOST_WRITES);
        u_chk.end_test();

        u_chk.start_test("instant_attack", 0);
        am = 7'($urandom % 128);
        for (int i = 0; i < 8; i++) begin
            keyed[i] = 5'(i * 4 + $urandom % 4);
            write_rate(keyed[i], 31, 0, 0, $urandom % 4, 0);
            write_level(keyed[i], 0, $urandom % 128, $urandom % 4, 1'b0, 1'b1, $urandom % 32);
        end
        wait_samples(3);
        u_chk.set_mode(2);
        wait_samples(3);
        u_chk.end_test();

        u_chk.start_test("am_scaling", 0);
        for (int r = 0; r < 4; r++) begin
            am = 7'($urandom % 128);
            for (int i = 0; i < 8; i++)
                write_level(keyed[i], 0, $urandom % 128, (i + r) % 4, i != 7, 1'b1,
                            $urandom % 32);
            wait_samples(3);
            u_chk.set_mode(2);
            wait_samples(2);
            u_chk.set_mode(0);
        end
        u_chk.end_test();

        // decay rates zero so key-on only ever lowers the level
        u_chk.start_test("env_bounds", 3);
        am = '0;
        for (int s = 0; s < 32; s++) begin
            write_rate(s, $urandom % 32, 0, 0, $urandom % 4, $urandom % 16);
            write_level(s, $urandom % 16, 0, 0, 1'b0, 1'b0, $urandom % 32);
        end
        wait_samples(20);
        for (int s = 0; s < 32; s++)
            write_level(s, $urandom % 16, 0, 0, 1'b0, 1'b1, $urandom % 32);
        wait_samples(30);
        for (int s = 0; s < 32; s++)
            write_level(s, $urandom % 16, 0, 0, 1'b0, 1'b0, $urandom % 32);
        wait_samples(30);
        u_chk.end_test();

        u_chk.start_test("release_done", 0);
        for (int s = 0; s < 32; s++)
            write_rate(s, 0, 0, 0, $urandom % 4, 15);
        u_chk.set_mode(4);
        waited = 0;
        while (!u_chk.released && waited < REL_SAMPLES) begin
            wait_samples(1);
            waited++;
        end
        if (!u_chk.released)
            u_chk.note_failure("not every slot reached 1023 within the release bound");
        else
            wait_samples(3);
        u_chk.end_test();

        u_chk.summary();
        if (u_chk.fail_cnt == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* project.f */
+incdir+verilog
verilog/eg_pkg.sv
verilog/eg_cfg_if.sv
verilog/slot_timer.sv
verilog/shift_line.sv
verilog/op_regs.sv
verilog/env_gen.sv
verilog/eg_top.sv
testbench/eg_checker.sv
testbench/tb_eg.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the envelope generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_eg -o sim_eg \
    > build.log 2>&1 \
    && ./obj_dir/sim_eg > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
    || grep -q "TEST OK" sim.log || { echo "no result line in sim.log"; exit 1; }
